//--- compile.f
design/dcacheGeometryPkg.sv
design/dcacheCtrlPkg.sv
design/memLatencyTimer.sv
design/blockMemory.sv
design/dcacheArray.sv
design/dcacheController.sv
design/dcacheTop.sv
verif/dcacheCtrl_props.sv
verif/dcacheChecker.sv
verif/dcacheTb.sv

//--- verif/dcacheTb.sv
/*
 * Data cache testbench. Applies a table of directed accesses and a run
 * of pseudo-random ones, then prints the error counts and the verdict.
 */
`timescale 1ns/1ps

module dcacheTb;

    // operation codes, bit 0 drives ren and bit 1 drives wen
    localparam logic [1:0] OpRead = 2'd1;
    localparam logic [1:0] OpWrite = 2'd2;
    localparam logic [1:0] OpBoth = 2'd3;

    // expected stall in the first cycle of an entry
    localparam logic [1:0] StallNo = 2'd0;
    localparam logic [1:0] StallYes = 2'd1;
    localparam logic [1:0] StallAny = 2'd2;

    localparam int NumRandom = 40;
    localparam int ResetCycles = 8;

    typedef struct packed {
        logic [127:0] name;
        logic [1:0] op;
        logic [dcacheGeometryPkg::AddrWidth-1:0] addr;
        logic [dcacheGeometryPkg::WordBytes-1:0] mask;
        logic [dcacheGeometryPkg::WordWidth-1:0] data;
        logic [1:0] stallExpect;
    } entry_t;

    logic clock;
    logic reset;
    logic ren;
    logic wen;
    logic [dcacheGeometryPkg::AddrWidth-1:0] addr;
    logic [dcacheGeometryPkg::WordBytes-1:0] byteSelect;
    logic [dcacheGeometryPkg::WordWidth-1:0] din;
    logic stall;
    logic [dcacheGeometryPkg::WordWidth-1:0] dout;

    logic [127:0] testName;
    logic [1:0] stallExpect;
    logic entryStart;
    int readErrors;
    int stallErrors;

    entry_t stimulus[$];
    logic [31:0] lfsrState;

    // random accesses stay on four sets and two tags so lines get evicted
    logic [3:0] setList [4] = '{4'h3, 4'h5, 4'hA, 4'hC};
    logic [3:0] tagList [2] = '{4'h2, 4'h9};

    dcacheTop DUT (
        .clock      (clock),
        .reset      (reset),
        .ren        (ren),
        .wen        (wen),
        .addr       (addr),
        .byteSelect (byteSelect),
        .din        (din),
        .stall      (stall),
        .dout       (dout)
    );

    dcacheChecker dataChecker (
        .clock       (clock),
        .reset       (reset),
        .ren         (ren),
        .wen         (wen),
        .addr        (addr),
        .byteSelect  (byteSelect),
        .din         (din),
        .stall       (stall),
        .dout        (dout),
        .testName    (testName),
        .stallExpect (stallExpect),
        .entryStart  (entryStart),
        .readErrors  (readErrors),
        .stallErrors (stallErrors)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic drawBits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsrState[31]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic addEntry(input logic [127:0] name, input logic [1:0] op,
                            input logic [11:0] entryAddr, input logic [3:0] mask,
                            input logic [31:0] data, input logic [1:0] stallExp);
        entry_t e;
        e.name = name;
        e.op = op;
        e.addr = entryAddr;
        e.mask = mask;
        e.data = data;
        e.stallExpect = stallExp;
        stimulus.push_back(e);
    endtask

    task automatic addRandomEntries();
        logic [31:0] opBit;
        logic [31:0] setSel;
        logic [31:0] tagSel;
        logic [31:0] wordSel;
        logic [31:0] mask;
        logic [31:0] data;
        for (int i = 0; i < NumRandom; i++) begin
            drawBits(1, opBit);
            drawBits(2, setSel);
            drawBits(1, tagSel);
            drawBits(2, wordSel);
            drawBits(4, mask);
            drawBits(32, data);
            addEntry("lfsrEntry", opBit[0] ? OpWrite : OpRead,
                     {tagList[tagSel[0]], setList[setSel[1:0]], wordSel[1:0], 2'b00},
                     mask[3:0], data, StallAny);
        end
    endtask

    // hold the entry until a cycle with stall low
    task automatic applyEntry(input entry_t e);
        @(posedge clock);
        ren <= e.op[0];
        wen <= e.op[1];
        addr <= e.addr;
        byteSelect <= e.mask;
        din <= e.data;
        testName <= e.name;
        stallExpect <= e.stallExpect;
        entryStart <= 1'b1;
        @(negedge clock);
        while (stall) begin
            @(posedge clock);
            entryStart <= 1'b0;
            @(negedge clock);
        end
    endtask

    initial begin
        reset = 1'b0;
        ren = 1'b0;
        wen = 1'b0;
        addr = '0;
        byteSelect = '0;
        din = '0;
        testName = '0;
        stallExpect = StallAny;
        entryStart = 1'b0;
        lfsrState = 32'h8821_17a2;

        addEntry("coldRead", OpRead, 12'h130, 4'hF, 32'h0, StallYes);
        addEntry("warmRead", OpRead, 12'h13C, 4'hF, 32'h0, StallNo);
        addEntry("partialWrite", OpWrite, 12'h134, 4'b0101, 32'hDEAD_BEEF, StallNo);
        addEntry("mergeRead", OpRead, 12'h134, 4'hF, 32'h0, StallNo);
        // same index, different tag, so the dirty line goes back to memory
        addEntry("dirtyWrite", OpWrite, 12'h250, 4'hF, 32'h1234_5678, StallYes);
        addEntry("evictRead", OpRead, 12'h650, 4'hF, 32'h0, StallYes);
        addEntry("reloadRead", OpRead, 12'h250, 4'hF, 32'h0, StallYes);
        addEntry("bothStrobes", OpBoth, 12'h250, 4'hF, 32'hFFFF_FFFF, StallNo);
        addEntry("bothMiss", OpBoth, 12'h650, 4'hF, 32'hFFFF_FFFF, StallNo);
        addEntry("afterBoth", OpRead, 12'h250, 4'hF, 32'h0, StallNo);
        addEntry("coldWrite", OpWrite, 12'h7A8, 4'b1000, 32'hAB00_0000, StallYes);
        addEntry("readBack", OpRead, 12'h7A8, 4'hF, 32'h0, StallNo);
        addRandomEntries();

        repeat (ResetCycles) @(posedge clock);
        reset <= 1'b1;

        foreach (stimulus[i]) begin
            applyEntry(stimulus[i]);
        end

        @(posedge clock);
        ren <= 1'b0;
        wen <= 1'b0;
        entryStart <= 1'b0;
        repeat (2) @(posedge clock);

        $display("checker: %0d read errors, %0d stall errors", readErrors, stallErrors);
        if (readErrors == 0 && stallErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // worst case per entry is a dirty miss plus the drive cycle
    initial begin
        int limit;
        @(posedge clock);
        limit = stimulus.size() * (4 + 2 * dcacheGeometryPkg::MemLatency) + ResetCycles;
        repeat (limit) @(posedge clock);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- verif/dcacheChecker.sv
/*
 * Data cache checker. Keeps a shadow copy of memory, applies completed
 * writes and compares completed reads and stall behaviour against it.
 */
`timescale 1ns/1ps

module dcacheChecker (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    ren,
    input  logic                                    wen,
    input  logic [dcacheGeometryPkg::AddrWidth-1:0] addr,
    input  logic [dcacheGeometryPkg::WordBytes-1:0] byteSelect,
    input  logic [dcacheGeometryPkg::WordWidth-1:0] din,
    input  logic                                    stall,
    input  logic [dcacheGeometryPkg::WordWidth-1:0] dout,
    input  logic [127:0]                            testName,
    input  logic [1:0]                              stallExpect,
    input  logic                                    entryStart,
    output int                                      readErrors,
    output int                                      stallErrors
);

    localparam int NumWords = 1 << (dcacheGeometryPkg::AddrWidth - 2);
    // request cycle plus the longest miss, the dirty one
    localparam int MaxStallCycles = 3 + 2 * dcacheGeometryPkg::MemLatency;

    logic [dcacheGeometryPkg::WordWidth-1:0] shadow [NumWords];
    logic [dcacheGeometryPkg::AddrWidth-3:0] wordAddr;
    int stallCycles;
    bit stallReported;

    assign wordAddr = addr[dcacheGeometryPkg::AddrWidth-1:2];

    // memory power-up contents, word address xor key
    initial begin
        for (int w = 0; w < NumWords; w++) begin
            shadow[w] = 32'(w) ^ dcacheGeometryPkg::MemInitKey;
        end
    end

    // inputs change on the rising edge, so sample on the falling one
    always @(negedge clock) begin
        logic [dcacheGeometryPkg::WordWidth-1:0] expected;
        if (reset) begin
            if (entryStart && stallExpect != 2'd2 && stall != stallExpect[0]) begin
                stallErrors++;
                $display("Error %0s: expected stall %0d, actual stall %0d",
                         testName, stallExpect[0], stall);
            end
            if ((ren ^ wen) && stall) begin
                stallCycles++;
                if (stallCycles > MaxStallCycles && !stallReported) begin
                    stallErrors++;
                    stallReported = 1'b1;
                    $display("request %0s at address %h stayed stalled for more than %0d cycles",
                             testName, addr, MaxStallCycles);
                end
            end else begin
                stallCycles = 0;
                stallReported = 1'b0;
            end
            // exactly one strobe and no stall means the access completes
            if ((ren ^ wen) && !stall) begin
                if (ren) begin
                    expected = shadow[wordAddr];
                    if (dout !== expected) begin
                        readErrors++;
                        $display("Error %0s: expected %h, actual %h", testName, expected, dout);
                    end
                end else begin
                    for (int b = 0; b < dcacheGeometryPkg::WordBytes; b++) begin
                        if (byteSelect[b]) begin
                            shadow[wordAddr][b*8 +: 8] = din[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

//--- verif/dcacheCtrl_props.sv
/*
 * Controller assertions on stall, fill, write-back and reset behaviour.
 */
`timescale 1ns/1ps

module dcacheCtrlProps (
    input logic                      clock,
    input logic                      reset,
    input dcacheCtrlPkg::ctrlState_e state,
    input logic                      dirty,
    input logic                      stall,
    input logic                      wordWen,
    input logic                      fillEn,
    input dcacheCtrlPkg::memOp_e     memOp
);

    // a busy controller always holds the pipeline
    stallWhenBusy: assert property (@(posedge clock) disable iff (!reset)
        state != dcacheCtrlPkg::Idle |-> stall)
        else $error("stall low while the controller is busy");

    fillOnlyInFill: assert property (@(posedge clock) disable iff (!reset)
        fillEn |-> state == dcacheCtrlPkg::MemFill)
        else $error("fill enable outside the fill state");

    // a write-back starts only from a miss on a dirty line
    writeBackAfterDirtyMiss: assert property (@(posedge clock) disable iff (!reset)
        (memOp == dcacheCtrlPkg::MemWriteOp && $past(memOp) != dcacheCtrlPkg::MemWriteOp)
        |-> $past(state == dcacheCtrlPkg::Miss && dirty))
        else $error("memory write without a dirty miss");

    quietInReset: assert property (@(negedge clock)
        !reset |-> (state == dcacheCtrlPkg::Idle && !stall && !wordWen && !fillEn
                    && memOp == dcacheCtrlPkg::MemNone))
        else $error("controller outputs active during reset");

endmodule

bind dcacheController dcacheCtrlProps ctrlProps (
    .clock   (clock),
    .reset   (reset),
    .state   (state),
    .dirty   (dirty),
    .stall   (stall),
    .wordWen (wordWen),
    .fillEn  (fillEn),
    .memOp   (memOp)
);

//--- design/dcacheTop.sv
/*
 * Data cache subsystem: controller, cache array and backing memory
 * between the pipeline load/store port and memory.
 */
`timescale 1ns/1ps

module dcacheTop (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    ren,
    input  logic                                    wen,
    input  logic [dcacheGeometryPkg::AddrWidth-1:0] addr,
    input  logic [dcacheGeometryPkg::WordBytes-1:0] byteSelect,
    input  logic [dcacheGeometryPkg::WordWidth-1:0] din,
    output logic                                    stall,
    output logic [dcacheGeometryPkg::WordWidth-1:0] dout
);

    logic hit;
    logic dirty;
    logic wordWen;
    logic fillEn;
    logic readReady;
    logic writeDone;
    logic [dcacheGeometryPkg::BlockAddrWidth-1:0] victimBlockAddr;
    logic [dcacheGeometryPkg::BlockAddrWidth-1:0] memBlockAddr;
    logic [dcacheGeometryPkg::BlockWidth-1:0] evictData;
    logic [dcacheGeometryPkg::BlockWidth-1:0] memData;
    dcacheCtrlPkg::memOp_e memOp;

    dcacheController controller (
        .clock           (clock),
        .reset           (reset),
        .ren             (ren),
        .wen             (wen),
        .addr            (addr),
        .hit             (hit),
        .dirty           (dirty),
        .victimBlockAddr (victimBlockAddr),
        .readReady       (readReady),
        .writeDone       (writeDone),
        .stall           (stall),
        .wordWen         (wordWen),
        .fillEn          (fillEn),
        .memOp           (memOp),
        .memBlockAddr    (memBlockAddr)
    );

    dcacheArray cacheArray (
        .clock           (clock),
        .reset           (reset),
        .addr            (addr),
        .byteSelect      (byteSelect),
        .din             (din),
        .wordWen         (wordWen),
        .fillEn          (fillEn),
        .fillData        (memData),
        .hit             (hit),
        .dirty           (dirty),
        .dout            (dout),
        .evictData       (evictData),
        .victimBlockAddr (victimBlockAddr)
    );

    blockMemory backingMemory (
        .clock     (clock),
        .reset     (reset),
        .memOp     (memOp),
        .blockAddr (memBlockAddr),
        .writeData (evictData),
        .readData  (memData),
        .readReady (readReady),
        .writeDone (writeDone)
    );

endmodule

//--- design/dcacheController.sv
/*
 * Data cache controller. Detects misses, stalls the pipeline and walks
 * through write-back of a dirty victim, block fetch and line fill.
 */
`timescale 1ns/1ps

module dcacheController (
    input  logic                                         clock,
    input  logic                                         reset,
    input  logic                                         ren,
    input  logic                                         wen,
    input  logic [dcacheGeometryPkg::AddrWidth-1:0]      addr,
    input  logic                                         hit,
    input  logic                                         dirty,
    input  logic [dcacheGeometryPkg::BlockAddrWidth-1:0] victimBlockAddr,
    input  logic                                         readReady,
    input  logic                                         writeDone,
    output logic                                         stall,
    output logic                                         wordWen,
    output logic                                         fillEn,
    output dcacheCtrlPkg::memOp_e                        memOp,
    output logic [dcacheGeometryPkg::BlockAddrWidth-1:0] memBlockAddr
);

    dcacheCtrlPkg::ctrlState_e state;
    dcacheCtrlPkg::ctrlState_e nextState;

    logic request;
    logic [dcacheGeometryPkg::BlockAddrWidth-1:0] requestBlockAddr;

    // both strobes high is treated as no request
    assign request = ren ^ wen;

    assign requestBlockAddr = addr[dcacheGeometryPkg::AddrWidth-1:dcacheGeometryPkg::OffsetWidth];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= dcacheCtrlPkg::Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            dcacheCtrlPkg::Idle: begin
                if (request && !hit) begin
                    nextState = dcacheCtrlPkg::Miss;
                end
            end
            dcacheCtrlPkg::Miss: begin
                // victim must go out before the new block comes in
                if (dirty) begin
                    nextState = dcacheCtrlPkg::WriteBack;
                end else begin
                    nextState = dcacheCtrlPkg::MemRead;
                end
            end
            dcacheCtrlPkg::WriteBack: begin
                if (writeDone) begin
                    nextState = dcacheCtrlPkg::MemRead;
                end
            end
            dcacheCtrlPkg::MemRead: begin
                if (readReady) begin
                    nextState = dcacheCtrlPkg::MemFill;
                end
            end
            dcacheCtrlPkg::MemFill: begin
                nextState = dcacheCtrlPkg::Idle;
            end
            default: begin
                nextState = dcacheCtrlPkg::Idle;
            end
        endcase
    end

    // stall is combinational in idle so a miss holds the pipeline at once
    always_comb begin
        stall = 1'b1;
        wordWen = 1'b0;
        fillEn = 1'b0;
        memOp = dcacheCtrlPkg::MemNone;
        case (state)
            dcacheCtrlPkg::Idle: begin
                stall = request && !hit;
                wordWen = wen && !ren && hit;
            end
            dcacheCtrlPkg::WriteBack: begin
                memOp = dcacheCtrlPkg::MemWriteOp;
            end
            dcacheCtrlPkg::MemRead: begin
                memOp = dcacheCtrlPkg::MemReadOp;
            end
            dcacheCtrlPkg::MemFill: begin
                fillEn = 1'b1;
            end
            default: begin
                memOp = dcacheCtrlPkg::MemNone;
            end
        endcase
    end

    // victim address only while writing back, otherwise the requested block
    always_comb begin
        if (state == dcacheCtrlPkg::WriteBack) begin
            memBlockAddr = victimBlockAddr;
        end else begin
            memBlockAddr = requestBlockAddr;
        end
    end

endmodule

//--- design/dcacheArray.sv
/*
 * Direct-mapped cache storage: tag, valid and dirty per line plus block
 * data. Reports hit and victim, reads a word, merges byte writes, fills blocks.
 */
`timescale 1ns/1ps

module dcacheArray (
    input  logic                                         clock,
    input  logic                                         reset,
    input  logic [dcacheGeometryPkg::AddrWidth-1:0]      addr,
    input  logic [dcacheGeometryPkg::WordBytes-1:0]      byteSelect,
    input  logic [dcacheGeometryPkg::WordWidth-1:0]      din,
    input  logic                                         wordWen,
    input  logic                                         fillEn,
    input  logic [dcacheGeometryPkg::BlockWidth-1:0]     fillData,
    output logic                                         hit,
    output logic                                         dirty,
    output logic [dcacheGeometryPkg::WordWidth-1:0]      dout,
    output logic [dcacheGeometryPkg::BlockWidth-1:0]     evictData,
    output logic [dcacheGeometryPkg::BlockAddrWidth-1:0] victimBlockAddr
);

    logic [dcacheGeometryPkg::NumLines-1:0] validBits;
    logic [dcacheGeometryPkg::NumLines-1:0] dirtyBits;
    logic [dcacheGeometryPkg::TagWidth-1:0] tagMem [dcacheGeometryPkg::NumLines];
    logic [dcacheGeometryPkg::BlockWidth-1:0] dataMem [dcacheGeometryPkg::NumLines];

    logic [dcacheGeometryPkg::IndexWidth-1:0] index;
    logic [dcacheGeometryPkg::TagWidth-1:0] tag;
    logic [dcacheGeometryPkg::WordSelWidth-1:0] wordSel;
    logic [dcacheGeometryPkg::BlockWidth-1:0] lineData;
    logic [dcacheGeometryPkg::BlockWidth-1:0] mergedBlock;

    // address split: tag | index | word | byte
    assign index = addr[dcacheGeometryPkg::OffsetWidth +: dcacheGeometryPkg::IndexWidth];
    assign tag = addr[dcacheGeometryPkg::AddrWidth-1 -: dcacheGeometryPkg::TagWidth];
    assign wordSel = addr[dcacheGeometryPkg::OffsetWidth-1 -: dcacheGeometryPkg::WordSelWidth];

    assign lineData = dataMem[index];

    assign hit = validBits[index] && (tagMem[index] == tag);
    assign dirty = validBits[index] && dirtyBits[index];
    assign dout = lineData[wordSel*dcacheGeometryPkg::WordWidth +: dcacheGeometryPkg::WordWidth];

    // victim is whatever currently sits in the addressed line
    assign evictData = lineData;
    assign victimBlockAddr = {tagMem[index], index};

    // new bytes dropped into the addressed word of the line
    always_comb begin
        mergedBlock = lineData;
        for (int b = 0; b < dcacheGeometryPkg::WordBytes; b++) begin
            if (byteSelect[b]) begin
                mergedBlock[(wordSel*dcacheGeometryPkg::WordBytes + b)*8 +: 8] = din[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fillEn) begin
            dataMem[index] <= fillData;
        end else if (wordWen) begin
            dataMem[index] <= mergedBlock;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            validBits <= '0;
            dirtyBits <= '0;
            for (int i = 0; i < dcacheGeometryPkg::NumLines; i++) begin
                tagMem[i] <= '0;
            end
        end else begin
            if (fillEn) begin
                // freshly fetched block is clean
                validBits[index] <= 1'b1;
                dirtyBits[index] <= 1'b0;
                tagMem[index] <= tag;
            end else if (wordWen) begin
                dirtyBits[index] <= 1'b1;
            end
        end
    end

endmodule

//--- design/blockMemory.sv
/*
 * Block-wide backing memory with a fixed access latency. Held read and
 * write operations are answered by one-cycle ready and done pulses.
 */
`timescale 1ns/1ps

module blockMemory (
    input  logic                                         clock,
    input  logic                                         reset,
    input  dcacheCtrlPkg::memOp_e                        memOp,
    input  logic [dcacheGeometryPkg::BlockAddrWidth-1:0] blockAddr,
    input  logic [dcacheGeometryPkg::BlockWidth-1:0]     writeData,
    output logic [dcacheGeometryPkg::BlockWidth-1:0]     readData,
    output logic                                         readReady,
    output logic                                         writeDone
);

    logic [dcacheGeometryPkg::BlockWidth-1:0] mem [dcacheGeometryPkg::NumBlocks];
    logic timerDone;

    memLatencyTimer latencyTimer (
        .clock (clock),
        .reset (reset),
        .memOp (memOp),
        .done  (timerDone)
    );

    // power-up pattern, each word holds its word address xor the key
    initial begin
        for (int b = 0; b < dcacheGeometryPkg::NumBlocks; b++) begin
            for (int w = 0; w < dcacheGeometryPkg::BlockBytes / dcacheGeometryPkg::WordBytes;
                 w++) begin
                mem[b][w*dcacheGeometryPkg::WordWidth +: dcacheGeometryPkg::WordWidth] =
                    dcacheGeometryPkg::WordWidth'(b * (dcacheGeometryPkg::BlockBytes /
                    dcacheGeometryPkg::WordBytes) + w) ^ dcacheGeometryPkg::MemInitKey;
            end
        end
    end

    assign readData = mem[blockAddr];

    assign readReady = timerDone && (memOp == dcacheCtrlPkg::MemReadOp);
    assign writeDone = timerDone && (memOp == dcacheCtrlPkg::MemWriteOp);

    // write lands together with the done pulse
    always_ff @(posedge clock) begin
        if (writeDone) begin
            mem[blockAddr] <= writeData;
        end
    end

endmodule

//--- design/memLatencyTimer.sv
/*
 * Memory latency timer. Counts the fixed access latency of each new
 * memory operation and pulses done in its last cycle.
 */
`timescale 1ns/1ps

module memLatencyTimer (
    input  logic                  clock,
    input  logic                  reset,
    input  dcacheCtrlPkg::memOp_e memOp,
    output logic                  done
);

    dcacheCtrlPkg::memOp_e lastOp;

    logic [dcacheGeometryPkg::MemLatencyWidth-1:0] count;
    logic [dcacheGeometryPkg::MemLatencyWidth-1:0] current;
    logic newOp;

    // a change of operation restarts the count
    assign newOp = (memOp != lastOp);

    assign current = newOp ? dcacheGeometryPkg::MemLatencyWidth'(dcacheGeometryPkg::MemLatency)
                           : count;

    assign done = (memOp != dcacheCtrlPkg::MemNone) && (current == 1);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            lastOp <= dcacheCtrlPkg::MemNone;
            count <= '0;
        end else begin
            lastOp <= memOp;
            // rests at zero once done has fired
            if ((memOp != dcacheCtrlPkg::MemNone) && (current != 0)) begin
                count <= current - 1'b1;
            end else begin
                count <= '0;
            end
        end
    end

endmodule

//--- design/dcacheCtrlPkg.sv
/*
 * Data cache control encodings: miss-handling FSM states and the
 * operation the controller requests from the backing memory.
 */
package dcacheCtrlPkg;

    // miss handling sequence
    typedef enum logic [2:0] {
        Idle      = 3'd0,
        Miss      = 3'd1,
        WriteBack = 3'd2,
        MemRead   = 3'd3,
        MemFill   = 3'd4
    } ctrlState_e;

    // held for the whole memory access
    typedef enum logic [1:0] {
        MemNone    = 2'd0,
        MemReadOp  = 2'd1,
        MemWriteOp = 2'd2
    } memOp_e;

endpackage

//--- design/dcacheGeometryPkg.sv
/*
 * Data cache geometry: address split, cache and backing memory sizes,
 * and the fixed latency of the backing memory.
 */
package dcacheGeometryPkg;

    // byte address from the pipeline
    localparam int AddrWidth = 12;

    // word
    localparam int WordBytes = 4;
    localparam int WordWidth = 32;

    // block, the unit moved between cache and memory
    localparam int BlockBytes = 16;
    localparam int BlockWidth = 128;
    localparam int OffsetWidth = 4;

    // word index inside a block, addr[3:2]
    localparam int WordSelWidth = 2;

    // direct-mapped lines
    localparam int IndexWidth = 4;
    localparam int NumLines = 16;
    localparam int TagWidth = 4;

    // tag and index together address one memory block
    localparam int BlockAddrWidth = 8;
    localparam int NumBlocks = 256;

    // cycles from a memory strobe to its ready or done pulse
    localparam int MemLatency = 4;

    // counter width for the latency timer
    localparam int MemLatencyWidth = $clog2(MemLatency + 1);

    // power-up pattern, word address xor this key
    localparam logic [WordWidth-1:0] MemInitKey = 32'hA5A5_0000;

endpackage
